//--- common/vdc_reg_pkg.sv
`default_nettype none

package vdc_reg_pkg;

	typedef logic [5:0] reg_addr_t; // register index on the cpu port
	typedef logic [7:0] reg_byte_t; // one register value
	typedef logic [3:0] cth_t;      // cell width minus one
	typedef logic [4:0] ctv_t;      // cell height minus one

	localparam reg_addr_t reg_ht_a  = 6'd0;  // horizontal total minus one
	localparam reg_addr_t reg_hd_a  = 6'd1;  // horizontal displayed
	localparam reg_addr_t reg_hp_a  = 6'd2;  // hsync position
	localparam reg_addr_t reg_sw_a  = 6'd3;  // vsync width [7:4], hsync width [3:0]
	localparam reg_addr_t reg_vt_a  = 6'd4;  // vertical total minus one
	localparam reg_addr_t reg_va_a  = 6'd5;  // vertical total adjust, in lines
	localparam reg_addr_t reg_vd_a  = 6'd6;  // vertical displayed
	localparam reg_addr_t reg_vp_a  = 6'd7;  // vsync position
	localparam reg_addr_t reg_ctv_a = 6'd9;  // char total vertical
	localparam reg_addr_t reg_dsh_a = 6'd12; // display start, high byte
	localparam reg_addr_t reg_dsl_a = 6'd13; // display start, low byte
	localparam reg_addr_t reg_cth_a = 6'd22; // char total horizontal in [7:4]
	localparam reg_addr_t reg_col_a = 6'd26; // fg [7:4], bg [3:0]

endpackage

`default_nettype wire

//--- common/vdc_video_pkg.sv
`default_nettype none

package vdc_video_pkg;

	typedef logic [7:0]  col_t;   // character column
	typedef logic [7:0]  row_t;   // character row
	typedef logic [3:0]  pixel_t; // pixel inside a cell
	typedef logic [4:0]  cline_t; // scanline inside a row
	typedef logic [3:0]  rgbi_t;  // colour out
	typedef logic [15:0] vaddr_t; // video memory address

	// vertical state, adjust lines follow the last row
	typedef enum logic [0:0] {
		vp_rows,
		vp_adjust
	} vphase_e;

endpackage

`default_nettype wire

//--- sim/vdc_tb.sv
`timescale 1ns/10ps
`default_nettype none

module vdc_tb;

	localparam int clk_period = 40;
	localparam int n_tests    = 6;
	localparam int frame_clks = 13 * 12 * 8; // longest frame used is 13 lines of 12 cols x 8 px
	localparam int timeout_ns = (n_tests * 3 * frame_clks + 2000) * clk_period;
	localparam logic [31:0] seed = 32'h5f610468;

	logic                   clk;
	logic                   rst_n;
	vdc_reg_pkg::reg_addr_t reg_addr;
	vdc_reg_pkg::reg_byte_t reg_wdata;
	logic                   reg_we;
	vdc_reg_pkg::reg_byte_t reg_rdata;
	vdc_video_pkg::vaddr_t  vram_addr;
	logic [7:0]             vram_data = 8'h00;
	vdc_video_pkg::vaddr_t  mem_addr_q = '0; // address the memory took on the last rising edge
	vdc_video_pkg::rgbi_t   rgbi;
	logic                   hsync, vsync, hblank, vblank, de;

	// mode the testbench expects and keeps in step with the register writes
	int m_ht = 9, m_hd = 6, m_hw = 2, m_vt = 5, m_vd = 4, m_vw = 2;
	int m_va = 1, m_ctv = 1, m_cth = 7, m_vp = 5, m_start = 16'h12a4;
	int m_fg = 4'he, m_bg = 4'h1;

	int    cyc = 0;         // posedge count
	int    last_wr_cyc = 0; // clock of the last register write or reset release
	bit    in_restart = 0;  // timing checks count toward the restart test
	bit    restart_due = 0; // next vsync rise is timed from the ht rewrite
	int    test_checks [0:5];
	int    test_errs [0:5];
	string test_names [0:5] = '{"reg_readback", "h_timing", "v_timing",
		"display_window", "pixel_data", "restart"};

	// write values with unused bits set and the read-back they should give
	vdc_reg_pkg::reg_addr_t rb_addr [0:13] = '{vdc_reg_pkg::reg_ht_a, vdc_reg_pkg::reg_hd_a,
		vdc_reg_pkg::reg_hp_a, vdc_reg_pkg::reg_sw_a, vdc_reg_pkg::reg_vt_a,
		vdc_reg_pkg::reg_va_a, vdc_reg_pkg::reg_vd_a, vdc_reg_pkg::reg_vp_a,
		vdc_reg_pkg::reg_ctv_a, vdc_reg_pkg::reg_dsh_a, vdc_reg_pkg::reg_dsl_a,
		vdc_reg_pkg::reg_cth_a, vdc_reg_pkg::reg_col_a, 6'd31};
	logic [7:0] rb_wr [0:13] = '{8'h09, 8'h06, 8'h07, 8'h22, 8'h05, 8'he1, 8'h04,
		8'h05, 8'ha1, 8'h12, 8'ha4, 8'h7c, 8'he1, 8'h5a};
	logic [7:0] rb_rd [0:13] = '{8'h09, 8'h06, 8'h07, 8'h22, 8'h05, 8'h01, 8'h04,
		8'h05, 8'h01, 8'h12, 8'ha4, 8'h70, 8'he1, 8'h00};

	// monitor state
	bit hs_prev, vs_prev, de_prev;
	bit h_armed, h_pulse, v_armed, v_pulse, frame_armed, pix_armed;
	int h_last, v_last, hs_w, vs_w, de_cnt;
	int px, py; // position inside the visible frame

	vdc_top uut (
		.clk, .rst_n, .reg_addr, .reg_wdata, .reg_we, .reg_rdata,
		.vram_addr, .vram_data, .rgbi, .hsync, .vsync, .hblank, .vblank, .de
	);

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// bitmap byte hashed from every address bit
	function automatic logic [7:0] mem_byte(input logic [15:0] a);
		logic [31:0] h;
		h = xorshift(xorshift(seed ^ {a, ~a}));
		return h[7:0];
	endfunction

	function automatic int sync_len(input int w);
		return (w == 0) ? 16 : w; // zero width means 16
	endfunction

	function automatic int line_clks();
		return (m_ht + 1) * (m_cth + 1);
	endfunction

	function automatic int frame_lines();
		return (m_vt + 1) * (m_ctv + 1) + m_va; // adjust lines after the last row
	endfunction

	function automatic int grp(input int k);
		return in_restart ? 5 : k;
	endfunction

	// expected colour at visible pixel x of visible scanline y
	function automatic logic [3:0] ref_rgbi(input int x, input int y, input int start,
		input int hd);
		int         cw;
		int         c;
		int         p;
		logic [15:0] a;
		logic [7:0]  b;
		logic [3:0]  res;
		cw = m_cth + 1;
		c = x / cw;
		p = x % cw;
		a = start + y * hd + c; // wraps at 64k like the address counter
		b = mem_byte(a);
		if (p > 7)
			res = m_bg[3:0]; // wide cells run out of bits
		else
			res = b[7 - p] ? m_fg[3:0] : m_bg[3:0];
		return res;
	endfunction

	task automatic check(input int t, input string what, input logic [31:0] exp,
		input logic [31:0] act);
		test_checks[t]++;
		if (exp !== act) begin
			test_errs[t]++;
			$display("error %s %s: expected %0d, actual %0d", test_names[t], what, exp, act);
		end
	endtask

	task automatic write_reg(input vdc_reg_pkg::reg_addr_t a, input logic [7:0] d);
		@(negedge clk);
		reg_addr    = a;
		reg_wdata   = d;
		reg_we      = 1'b1;
		last_wr_cyc = cyc; // monitor holds off until the restart has flushed
		@(negedge clk);
		reg_we = 1'b0;
	endtask

	task automatic read_check(input vdc_reg_pkg::reg_addr_t a, input logic [7:0] exp);
		@(negedge clk);
		reg_addr = a;
		@(posedge clk);
		check(0, $sformatf("R%0d read-back", a), exp, reg_rdata);
	endtask

	task automatic report(input int t);
		if (test_checks[t] == 0) begin
			test_errs[t]++;
			$display("test %s ran no checks", test_names[t]);
		end
		$display("test %s: %0d checks, %0d errors", test_names[t], test_checks[t],
			test_errs[t]);
	endtask

	// synchronous memory takes the address on a rising edge
	always @(posedge clk)
		mem_addr_q <= vram_addr;

	// its byte is driven in the following clock
	always @(negedge clk)
		vram_data <= mem_byte(mem_addr_q);

	always @(posedge clk) begin
		cyc = cyc + 1;
		if (!rst_n || cyc <= last_wr_cyc + 4) begin
			h_armed     = 0; // old timing may still be in the pipe
			h_pulse     = 0;
			v_armed     = 0;
			v_pulse     = 0;
			frame_armed = 0;
			pix_armed   = 0;
		end else begin
			if (hsync && !hs_prev) begin
				if (h_armed)
					check(grp(1), "hsync period", line_clks(), cyc - h_last);
				h_last  = cyc;
				h_armed = 1;
				h_pulse = 1;
				hs_w    = 0;
			end
			if (!hsync && hs_prev && h_pulse)
				check(grp(1), "hsync width", sync_len(m_hw) * (m_cth + 1), hs_w);
			if (hsync)
				hs_w++;

			if (vsync && !vs_prev) begin
				// write edge, restart edge, two output stages and the sampling edge
				if (restart_due) begin
					check(5, "first vsync after restart",
						last_wr_cyc + 5 + m_vp * (m_ctv + 1) * line_clks(), cyc);
					restart_due = 0;
				end
				if (v_armed)
					check(grp(2), "vsync period", frame_lines() * line_clks(), cyc - v_last);
				if (frame_armed)
					check(grp(3), "de clocks per frame",
						m_hd * (m_cth + 1) * m_vd * (m_ctv + 1), de_cnt);
				v_last      = cyc;
				v_armed     = 1;
				v_pulse     = 1;
				vs_w        = 0;
				frame_armed = 1;
				de_cnt      = 0;
				pix_armed   = 1; // frame position known from here on
				px          = 0;
				py          = 0;
			end
			if (!vsync && vs_prev && v_pulse)
				check(grp(2), "vsync width", sync_len(m_vw) * line_clks(), vs_w);
			if (vsync)
				vs_w++;

			if (de)
				de_cnt++;
			check(grp(3), "de against hblank and vblank", !hblank && !vblank, de);

			if (de && pix_armed) begin
				check(grp(4), $sformatf("rgbi at x %0d y %0d", px, py),
					ref_rgbi(px, py, m_start, m_hd), rgbi);
				px++;
			end else if (!de) begin
				check(grp(4), "rgbi outside de", 0, rgbi);
			end
			if (!de && de_prev) begin
				px = 0; // visible line done
				py++;
			end
		end
		hs_prev = hsync;
		vs_prev = vsync;
		de_prev = de;
	end

	initial begin
		#(timeout_ns);
		$display("run timed out after %0d ns without finishing the tests", timeout_ns);
		$display("TEST FAILED");
		$finish;
	end

	initial begin
		int total_checks;
		int total_errs;
		rst_n     = 1'b0;
		reg_addr  = '0;
		reg_wdata = '0;
		reg_we    = 1'b0;
		repeat (8) @(negedge clk);
		rst_n       = 1'b1;
		last_wr_cyc = cyc;

		// program the small mode, then read every register back
		for (int i = 0; i < 14; i++)
			write_reg(rb_addr[i], rb_wr[i]);
		for (int i = 0; i < 14; i++)
			read_check(rb_addr[i], rb_rd[i]);
		report(0);

		// the monitor checks timing, window and pixels while frames run
		repeat (5) @(posedge vsync);
		repeat (2) @(negedge clk);
		for (int t = 1; t < 5; t++)
			report(t);

		// rewrite ht in the middle of a frame
		in_restart = 1;
		@(posedge vsync);
		repeat (300) @(negedge clk);
		write_reg(vdc_reg_pkg::reg_ht_a, 8'd11);
		m_ht        = 11; // monitor is still held off here
		restart_due = 1;
		repeat (4) @(posedge vsync);
		repeat (2) @(negedge clk);
		report(5);

		total_checks = 0;
		total_errs   = 0;
		for (int t = 0; t < n_tests; t++) begin
			total_checks += test_checks[t];
			total_errs   += test_errs[t];
		end
		$display("all tests: %0d checks, %0d errors", total_checks, total_errs);
		if (total_errs == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- src/vdc_addr_gen.sv
`timescale 1ns/10ps
`default_nettype none

module vdc_addr_gen (
	input  wire                       clk,
	input  wire                       rst_n,
	input  wire                       restart,
	input  wire                       new_col,
	input  wire                       line_end,
	input  wire                       frame_start,
	input  wire                       h_visible,
	input  wire                       v_visible,
	input  vdc_reg_pkg::reg_byte_t    hd,
	input  vdc_video_pkg::vaddr_t     start,
	output vdc_video_pkg::vaddr_t     vram_addr
);

	vdc_video_pkg::vaddr_t line_base; // address of column 0 on this scanline
	vdc_video_pkg::vaddr_t base_now;
	vdc_video_pkg::col_t   col_ofs;   // visible columns fetched so far
	logic                  fetch;

	assign fetch    = new_col && h_visible && v_visible;
	assign base_now = frame_start ? start : line_base; // first line uses start directly

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			line_base <= '0;
			col_ofs   <= '0;
			vram_addr <= '0;
		end else if (restart) begin
			line_base <= start;
			col_ofs   <= '0;
			vram_addr <= '0;
		end else begin
			if (frame_start)
				line_base <= start;
			else if (line_end && v_visible)
				line_base <= line_base + {8'h00, hd}; // bitmap is hd bytes wide
			if (line_end)
				col_ofs <= '0;
			else if (fetch)
				col_ofs <= col_ofs + 8'd1;
			if (fetch)
				vram_addr <= base_now + {8'h00, col_ofs};
		end
	end

endmodule

`default_nettype wire

//--- src/vdc_pixel_out.sv
`timescale 1ns/10ps
`default_nettype none

module vdc_pixel_out (
	input  wire                       clk,
	input  wire                       rst_n,
	input  wire                       restart,
	input  wire                       new_col,
	input  wire                       h_visible,
	input  wire                       v_visible,
	input  wire [7:0]                 vram_data,
	input  vdc_video_pkg::rgbi_t      fg,
	input  vdc_video_pkg::rgbi_t      bg,
	output vdc_video_pkg::rgbi_t      rgbi,
	output logic                      de
);

	logic       nc_d1;   // new_col in the address stage
	logic       nc_d2;   // new_col in the memory stage where vram_data holds the byte
	logic       vis_d1;
	logic [7:0] shreg;   // rest of the byte with the next pixel in the msb
	logic       cur_bit;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			nc_d1  <= 1'b0;
			nc_d2  <= 1'b0;
			vis_d1 <= 1'b0;
			de     <= 1'b0;
		end else if (restart) begin
			nc_d1  <= 1'b0;
			nc_d2  <= 1'b0;
			vis_d1 <= 1'b0;
			de     <= 1'b0;
		end else begin
			nc_d1  <= new_col;
			nc_d2  <= nc_d1;
			vis_d1 <= h_visible && v_visible;
			de     <= vis_d1;
		end
	end

	// zeros shift in, so wide cells fall back to bg
	always_ff @(posedge clk) begin
		if (nc_d2)
			shreg <= {vram_data[6:0], 1'b0};
		else
			shreg <= {shreg[6:0], 1'b0};
	end

	assign cur_bit = nc_d2 ? vram_data[7] : shreg[7]; // bit 7 shows on the fetch clock
	assign rgbi    = de ? (cur_bit ? fg : bg) : '0;

	// a shown pixel always comes from a byte that the memory returned
	a_pixel_known: assert property (@(posedge clk) disable iff (!rst_n)
		de |-> !$isunknown(cur_bit));

endmodule

`default_nettype wire

//--- src/vdc_regfile.sv
`timescale 1ns/10ps
`default_nettype none

module vdc_regfile (
	input  wire                       clk,
	input  wire                       rst_n,
	input  vdc_reg_pkg::reg_addr_t    reg_addr,
	input  vdc_reg_pkg::reg_byte_t    reg_wdata,
	input  wire                       reg_we,
	output vdc_reg_pkg::reg_byte_t    reg_rdata,
	output logic                      restart,
	output vdc_reg_pkg::reg_byte_t    ht,
	output vdc_reg_pkg::reg_byte_t    hd,
	output vdc_reg_pkg::reg_byte_t    hp,
	output vdc_reg_pkg::reg_byte_t    vt,
	output vdc_reg_pkg::reg_byte_t    vd,
	output vdc_reg_pkg::reg_byte_t    vp,
	output logic [3:0]                hw,
	output logic [3:0]                vw,
	output logic [4:0]                va,
	output vdc_reg_pkg::ctv_t         ctv,
	output vdc_reg_pkg::cth_t         cth,
	output vdc_video_pkg::vaddr_t     start,
	output vdc_video_pkg::rgbi_t      fg,
	output vdc_video_pkg::rgbi_t      bg
);

	logic timing_wr; // write hits a register that shapes the timing

	// R0..R9 and R22 all move the counters
	assign timing_wr = reg_we && (reg_addr <= vdc_reg_pkg::reg_ctv_a ||
		reg_addr == vdc_reg_pkg::reg_cth_a);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ht      <= 8'd126; // 80x25 text layout
			hd      <= 8'd80;
			hp      <= 8'd102;
			hw      <= 4'd9;
			vw      <= 4'd4;
			vt      <= 8'd32;
			va      <= 5'd0;
			vd      <= 8'd25;
			vp      <= 8'd29;
			ctv     <= 5'd7;   // 8 lines per row
			cth     <= 4'd7;   // 8 pixels per column
			start   <= '0;
			fg      <= 4'hf;   // white on black
			bg      <= 4'h0;
			restart <= 1'b0;
		end else begin
			restart <= timing_wr; // one clock after the write
			if (reg_we) begin
				case (reg_addr)
					vdc_reg_pkg::reg_ht_a:  ht <= reg_wdata;
					vdc_reg_pkg::reg_hd_a:  hd <= reg_wdata;
					vdc_reg_pkg::reg_hp_a:  hp <= reg_wdata;
					vdc_reg_pkg::reg_sw_a:  {vw, hw} <= reg_wdata;
					vdc_reg_pkg::reg_vt_a:  vt <= reg_wdata;
					vdc_reg_pkg::reg_va_a:  va <= reg_wdata[4:0];
					vdc_reg_pkg::reg_vd_a:  vd <= reg_wdata;
					vdc_reg_pkg::reg_vp_a:  vp <= reg_wdata;
					vdc_reg_pkg::reg_ctv_a: ctv <= reg_wdata[4:0];
					vdc_reg_pkg::reg_dsh_a: start[15:8] <= reg_wdata;
					vdc_reg_pkg::reg_dsl_a: start[7:0] <= reg_wdata;
					vdc_reg_pkg::reg_cth_a: cth <= reg_wdata[7:4]; // low nibble not kept
					vdc_reg_pkg::reg_col_a: {fg, bg} <= reg_wdata;
					default: ;
				endcase
			end
		end
	end

	// read back, missing bits as zero
	always_comb begin
		case (reg_addr)
			vdc_reg_pkg::reg_ht_a:  reg_rdata = ht;
			vdc_reg_pkg::reg_hd_a:  reg_rdata = hd;
			vdc_reg_pkg::reg_hp_a:  reg_rdata = hp;
			vdc_reg_pkg::reg_sw_a:  reg_rdata = {vw, hw};
			vdc_reg_pkg::reg_vt_a:  reg_rdata = vt;
			vdc_reg_pkg::reg_va_a:  reg_rdata = {3'b000, va};
			vdc_reg_pkg::reg_vd_a:  reg_rdata = vd;
			vdc_reg_pkg::reg_vp_a:  reg_rdata = vp;
			vdc_reg_pkg::reg_ctv_a: reg_rdata = {3'b000, ctv};
			vdc_reg_pkg::reg_dsh_a: reg_rdata = start[15:8];
			vdc_reg_pkg::reg_dsl_a: reg_rdata = start[7:0];
			vdc_reg_pkg::reg_cth_a: reg_rdata = {cth, 4'b0000};
			vdc_reg_pkg::reg_col_a: reg_rdata = {fg, bg};
			default:                reg_rdata = '0; // unmapped
		endcase
	end

endmodule

`default_nettype wire

//--- src/vdc_top.sv
`timescale 1ns/10ps
`default_nettype none

module vdc_top (
	input  wire                       clk,
	input  wire                       rst_n,
	input  vdc_reg_pkg::reg_addr_t    reg_addr,
	input  vdc_reg_pkg::reg_byte_t    reg_wdata,
	input  wire                       reg_we,
	output vdc_reg_pkg::reg_byte_t    reg_rdata,
	output vdc_video_pkg::vaddr_t     vram_addr,
	input  wire [7:0]                 vram_data,
	output vdc_video_pkg::rgbi_t      rgbi,
	output logic                      hsync,
	output logic                      vsync,
	output logic                      hblank,
	output logic                      vblank,
	output logic                      de
);

	logic                   restart;
	vdc_reg_pkg::reg_byte_t ht, hd, hp, vt, vd, vp;
	logic [3:0]             hw, vw;
	logic [4:0]             va;
	vdc_reg_pkg::ctv_t      ctv;
	vdc_reg_pkg::cth_t      cth;
	vdc_video_pkg::vaddr_t  start;
	vdc_video_pkg::rgbi_t   fg, bg;
	logic                   new_col, line_start, line_end, frame_start;
	vdc_video_pkg::col_t    col;
	vdc_video_pkg::row_t    row;
	vdc_video_pkg::cline_t  line;
	logic                   h_visible, v_visible;

	vdc_regfile u_regfile (
		.clk, .rst_n, .reg_addr, .reg_wdata, .reg_we, .reg_rdata, .restart,
		.ht, .hd, .hp, .vt, .vd, .vp, .hw, .vw, .va, .ctv, .cth, .start, .fg, .bg
	);

	// pixel, end_col and vphase only matter inside the counter block
	vdc_signals u_signals (
		.clk, .rst_n, .restart, .ht, .hd, .vt, .vd, .va, .cth, .ctv,
		.new_col, .end_col(), .line_start, .line_end, .frame_start,
		.col, .row, .pixel(), .line, .h_visible, .v_visible, .vphase()
	);

	vdc_sync_gen u_sync_gen (
		.clk, .rst_n, .restart, .new_col, .line_start, .col, .row, .line,
		.h_visible, .v_visible, .hp, .vp, .hw, .vw, .hsync, .vsync, .hblank, .vblank
	);

	vdc_addr_gen u_addr_gen (
		.clk, .rst_n, .restart, .new_col, .line_end, .frame_start,
		.h_visible, .v_visible, .hd, .start, .vram_addr
	);

	vdc_pixel_out u_pixel_out (
		.clk, .rst_n, .restart, .new_col, .h_visible, .v_visible,
		.vram_data, .fg, .bg, .rgbi, .de
	);

endmodule

`default_nettype wire

//--- vdc_timing/vdc_signals.sv
`timescale 1ns/10ps
`default_nettype none

module vdc_signals (
	input  wire                       clk,
	input  wire                       rst_n,
	input  wire                       restart,
	input  vdc_reg_pkg::reg_byte_t    ht,
	input  vdc_reg_pkg::reg_byte_t    hd,
	input  vdc_reg_pkg::reg_byte_t    vt,
	input  vdc_reg_pkg::reg_byte_t    vd,
	input  wire [4:0]                 va,
	input  vdc_reg_pkg::cth_t         cth,
	input  vdc_reg_pkg::ctv_t         ctv,
	output logic                      new_col,
	output logic                      end_col,
	output logic                      line_start,
	output logic                      line_end,
	output logic                      frame_start,
	output vdc_video_pkg::col_t       col,
	output vdc_video_pkg::row_t       row,
	output vdc_video_pkg::pixel_t     pixel,
	output vdc_video_pkg::cline_t     line,
	output logic                      h_visible,
	output logic                      v_visible,
	output vdc_video_pkg::vphase_e    vphase
);

	// cell and line strobes come straight from the counters
	assign new_col     = (pixel == '0);
	assign end_col     = (pixel == cth);
	assign line_start  = new_col && (col == '0);
	assign line_end    = end_col && (col == ht);
	assign frame_start = line_start && (row == '0) && (line == '0) &&
		(vphase == vdc_video_pkg::vp_rows);

	assign h_visible = (col < hd);
	assign v_visible = (vphase == vdc_video_pkg::vp_rows) && (row < vd); // adjust lines stay dark

	// horizontal: pixel within cell, then column
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pixel <= '0;
			col   <= '0;
		end else if (restart) begin
			pixel <= '0;
			col   <= '0;
		end else if (end_col) begin
			pixel <= '0;
			col   <= (col == ht) ? '0 : col + 8'd1; // wrap after ht
		end else begin
			pixel <= pixel + 4'd1;
		end
	end

	// vertical: line within row, row, then the adjust lines
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			line   <= '0;
			row    <= '0;
			vphase <= vdc_video_pkg::vp_rows;
		end else if (restart) begin
			line   <= '0;
			row    <= '0;
			vphase <= vdc_video_pkg::vp_rows;
		end else if (line_end) begin
			case (vphase)
				vdc_video_pkg::vp_rows: begin
					if (line == ctv) begin
						line <= '0;
						if (row == vt && va == '0) begin
							row <= '0; // no adjust, next frame
						end else begin
							row <= row + 8'd1; // adjust lines sit on row vt+1
							if (row == vt)
								vphase <= vdc_video_pkg::vp_adjust;
						end
					end else begin
						line <= line + 5'd1;
					end
				end
				vdc_video_pkg::vp_adjust: begin
					if (line == va - 5'd1) begin
						line   <= '0;
						row    <= '0;
						vphase <= vdc_video_pkg::vp_rows;
					end else begin
						line <= line + 5'd1;
					end
				end
				default: vphase <= vdc_video_pkg::vp_rows;
			endcase
		end
	end

	// a new ht only takes hold once the restart pulse has cleared col
	a_col_in_range: assert property (@(posedge clk) disable iff (!rst_n)
		!restart && !$past(restart) |-> col <= ht);

endmodule

`default_nettype wire

//--- vdc_timing/vdc_sync_gen.sv
`timescale 1ns/10ps
`default_nettype none

module vdc_sync_gen (
	input  wire                       clk,
	input  wire                       rst_n,
	input  wire                       restart,
	input  wire                       new_col,
	input  wire                       line_start,
	input  vdc_video_pkg::col_t       col,
	input  vdc_video_pkg::row_t       row,
	input  vdc_video_pkg::cline_t     line,
	input  wire                       h_visible,
	input  wire                       v_visible,
	input  vdc_reg_pkg::reg_byte_t    hp,
	input  vdc_reg_pkg::reg_byte_t    vp,
	input  wire [3:0]                 hw,
	input  wire [3:0]                 vw,
	output logic                      hsync,
	output logic                      vsync,
	output logic                      hblank,
	output logic                      vblank
);

	logic [4:0] hw_eff;  // sync widths, 0 stands for 16
	logic [4:0] vw_eff;
	logic [4:0] hs_left; // columns of hsync still to go
	logic [4:0] vs_left; // scanlines of vsync still to go
	logic       hs_load;
	logic       vs_load;
	logic       hb_d1;   // first blank stage
	logic       vb_d1;

	assign hw_eff  = (hw == '0) ? 5'd16 : {1'b0, hw};
	assign vw_eff  = (vw == '0) ? 5'd16 : {1'b0, vw};
	assign hs_load = new_col && (col == hp);
	assign vs_load = line_start && (row == vp) && (line == '0);

	// width counters lag the counters by one clock, the output flop adds the second
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			hs_left <= '0;
			vs_left <= '0;
		end else if (restart) begin
			hs_left <= '0;
			vs_left <= '0;
		end else begin
			if (hs_load)
				hs_left <= hw_eff;
			else if (new_col && hs_left != '0)
				hs_left <= hs_left - 5'd1; // one per column
			if (vs_load)
				vs_left <= vw_eff;
			else if (line_start && vs_left != '0)
				vs_left <= vs_left - 5'd1; // one per scanline
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			hsync  <= 1'b0;
			vsync  <= 1'b0;
			hb_d1  <= 1'b1;
			vb_d1  <= 1'b1;
			hblank <= 1'b1;
			vblank <= 1'b1;
		end else if (restart) begin
			hsync  <= 1'b0;
			vsync  <= 1'b0;
			hb_d1  <= 1'b1;
			vb_d1  <= 1'b1;
			hblank <= 1'b1;
			vblank <= 1'b1;
		end else begin
			hsync  <= (hs_left != '0);
			vsync  <= (vs_left != '0);
			hb_d1  <= !h_visible;
			vb_d1  <= !v_visible;
			hblank <= hb_d1; // two clocks, same as the pixel path
			vblank <= vb_d1;
		end
	end

	// vsync must end before the frame comes round to row vp again
	a_vsync_no_retrigger: assert property (@(posedge clk) disable iff (!rst_n || restart)
		vs_load |-> vs_left == '0);

endmodule

`default_nettype wire

//--- vdc_top.f
common/vdc_reg_pkg.sv
common/vdc_video_pkg.sv
src/vdc_regfile.sv
vdc_timing/vdc_signals.sv
vdc_timing/vdc_sync_gen.sv
src/vdc_addr_gen.sv
src/vdc_pixel_out.sv
src/vdc_top.sv
sim/vdc_tb.sv
